// File: sources.f
verilog/hitMapGeomPkg.sv
verilog/hitMapReqPkg.sv
verilog/hitRowMemory.sv
verilog/hitMapClearer.sv
verilog/hitUpdatePipe.sv
verilog/hitMapTop.sv
test/hitMapTb.sv

// File: run.sh
#!/bin/sh
# compile and run the hit map testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module hitMapTb -f sources.f -o hitMapSim
./obj_dir/hitMapSim > sim.log
cat sim.log
if grep -qx "test passed" sim.log; then
    echo "simulation ok"
    exit 0
fi
echo "simulation reported a failure, see sim.log"
exit 1

// File: test/hitMapTb.sv
`timescale 1ns/100ps

module hitMapTb;

    localparam int RespDelay = 3;   // accept edge to retire cycle

    typedef enum logic [1:0] {stepIssue, stepRandom, stepDrain, stepReset} stepKindT;

    typedef struct {
        stepKindT            kind;
        hitMapReqPkg::hitOpT op;
        hitMapGeomPkg::ssidT ssid;      // row reads use only the upper bits
        int                  count;     // repeats of this row
        int                  step;      // ssid increment between repeats
    } stepT;

    typedef struct {
        hitMapReqPkg::hitOpT   op;
        hitMapGeomPkg::ssidT   ssid;
        logic                  bitVal;
        hitMapGeomPkg::hitRowT row;
        int                    cycle;   // cycle the response must show up in
    } expRespT;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  reqValid;
    hitMapReqPkg::hitOpT   reqOp;
    hitMapGeomPkg::ssidT   reqSsid;
    logic                  respValid;
    hitMapGeomPkg::ssidT   respSsid;
    logic                  respBit;
    hitMapGeomPkg::hitRowT respRow;
    logic                  creditReturn;
    logic                  busy;

    stepT                      steps [$];
    expRespT                   expQ [$];   // reads still waiting for a response
    hitMapGeomPkg::hitRowT     model [hitMapGeomPkg::NumRows];
    hitMapReqPkg::creditCountT credits;    // credits the host holds
    int                        issued;
    int                        returned;
    int                        cycle = 0;
    int                        errorCount = 0;
    int                        checkCount = 0;
    int                        watchdogCycles = 0;
    logic [31:0]               lfsr;

    always #4 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    hitMapTop u_dut (
        .clk          (clk),
        .reset        (reset),
        .reqValid     (reqValid),
        .reqOp        (reqOp),
        .reqSsid      (reqSsid),
        .respValid    (respValid),
        .respSsid     (respSsid),
        .respBit      (respBit),
        .respRow      (respRow),
        .creditReturn (creditReturn),
        .busy         (busy)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            val  = {val[30:0], lfsr[0]};  // one step per bit
        end
    endtask

    task automatic checkSsid(input string name, input hitMapGeomPkg::ssidT got,
                             input hitMapGeomPkg::ssidT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkRow(input string name, input hitMapGeomPkg::hitRowT got,
                            input hitMapGeomPkg::hitRowT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkCredits(input string name, input hitMapReqPkg::creditCountT got,
                                input hitMapReqPkg::creditCountT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // samples the registered outputs 1 ns after each rising edge
    task automatic observe();
        expRespT e;
        if (creditReturn === 1'b1) begin
            credits++;
            returned++;
        end
        if (respValid === 1'b1) begin
            if (expQ.size() == 0) begin
                errorCount++;
                $display("response at cycle %0d with no read outstanding", cycle);
            end else begin
                e = expQ.pop_front();
                checkSsid("respSsid", respSsid, e.ssid);
                if (e.op == hitMapReqPkg::opReadBit) checkBit("respBit", respBit, e.bitVal);
                else checkRow("respRow", respRow, e.row);
                if (cycle != e.cycle) begin
                    errorCount++;
                    $display("response for ssid %h came in cycle %0d instead of %0d",
                             e.ssid, cycle, e.cycle);
                end
            end
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
        observe();
    endtask

    task automatic issueReq(input hitMapReqPkg::hitOpT op, input hitMapGeomPkg::ssidT ssid);
        hitMapGeomPkg::rowIndexT row;
        hitMapGeomPkg::colIndexT col;
        expRespT                 e;
        row = hitMapGeomPkg::rowIndexT'(ssid >> hitMapGeomPkg::ColBits);
        col = hitMapGeomPkg::colIndexT'(ssid);
        while (credits == 0 || busy !== 1'b0) tick();   // need a credit and an idle map
        reqValid = 1'b1;
        reqOp    = op;
        reqSsid  = ssid;
        credits--;
        issued++;
        e.op     = op;
        e.ssid   = ssid;
        e.bitVal = model[row][col];    // model state before this request
        e.row    = model[row];
        e.cycle  = cycle + 1 + RespDelay;   // accepted at the next edge
        if (op == hitMapReqPkg::opSetHit) model[row][col] = 1'b1;
        else expQ.push_back(e);
        tick();
        reqValid = 1'b0;                // next issue may raise it again right away
    endtask

    task automatic drainPipe();
        int waitCycles;
        waitCycles = 0;
        while ((credits != hitMapReqPkg::creditCountT'(hitMapReqPkg::NumCredits) ||
                expQ.size() != 0) && waitCycles < 20) begin
            tick();
            waitCycles++;
        end
        checkCredits("hostCredits", credits,
                     hitMapReqPkg::creditCountT'(hitMapReqPkg::NumCredits));
        if (returned != issued) begin
            errorCount++;
            $display("%0d requests issued but %0d credits returned", issued, returned);
        end
        if (expQ.size() != 0) begin
            errorCount++;
            $display("%0d read responses never arrived", expQ.size());
        end
    endtask

    task automatic applyReset();
        int busyCycles;
        busyCycles = 0;
        reqValid = 1'b0;
        reset    = 1'b1;
        repeat (2) begin
            tick();
            if (busy !== 1'b1) begin
                errorCount++;
                $display("busy low while reset is held");
            end
            if (respValid !== 1'b0 || creditReturn !== 1'b0) begin
                errorCount++;
                $display("response or credit pulse while reset is held");
            end
        end
        reset = 1'b0;
        expQ.delete();
        credits  = hitMapReqPkg::creditCountT'(hitMapReqPkg::NumCredits);
        issued   = 0;
        returned = 0;
        foreach (model[r]) model[r] = '0;
        while (busy === 1'b1 && busyCycles <= hitMapGeomPkg::NumRows + 4) begin
            if (respValid !== 1'b0 || creditReturn !== 1'b0) begin
                errorCount++;
                $display("response or credit pulse while the map is being cleared");
            end
            busyCycles++;
            tick();
        end
        if (busyCycles != hitMapGeomPkg::NumRows) begin
            errorCount++;
            $display("busy stayed high for %0d cycles after reset, expected %0d",
                     busyCycles, hitMapGeomPkg::NumRows);
        end
    endtask

    task automatic runStep(input stepT s);
        hitMapGeomPkg::ssidT ssid;
        hitMapReqPkg::hitOpT op;
        logic [31:0]         r;
        ssid = s.ssid;
        case (s.kind)
            stepIssue: begin
                repeat (s.count) begin
                    issueReq(s.op, ssid);
                    ssid = hitMapGeomPkg::ssidT'(int'(ssid) + s.step);
                end
            end
            stepRandom: begin
                repeat (s.count) begin
                    takeBits(1, r);
                    if (r[0]) begin
                        op = hitMapReqPkg::opSetHit;    // about half are set hits
                    end else begin
                        takeBits(1, r);
                        op = r[0] ? hitMapReqPkg::opReadRow : hitMapReqPkg::opReadBit;
                    end
                    takeBits(hitMapGeomPkg::RowBits + hitMapGeomPkg::ColBits, r);
                    issueReq(op, hitMapGeomPkg::ssidT'(r));
                end
            end
            stepDrain: drainPipe();
            default:   applyReset();
        endcase
    endtask

    task automatic addStep(input stepKindT kind, input hitMapReqPkg::hitOpT op,
                           input hitMapGeomPkg::ssidT ssid, input int count, input int step);
        stepT s;
        s.kind  = kind;
        s.op    = op;
        s.ssid  = ssid;
        s.count = count;
        s.step  = step;
        steps.push_back(s);
    endtask

    task automatic loadTable();
        addStep(stepReset,  hitMapReqPkg::opSetHit,  8'h00, 1, 0);
        addStep(stepIssue,  hitMapReqPkg::opReadRow, 8'h00, 16, 16);   // every row empty
        addStep(stepIssue,  hitMapReqPkg::opReadBit, 8'h00, 8, 37);
        addStep(stepDrain,  hitMapReqPkg::opSetHit,  8'h00, 1, 0);
        addStep(stepIssue,  hitMapReqPkg::opSetHit,  8'h35, 1, 0);     // single hit
        addStep(stepIssue,  hitMapReqPkg::opReadBit, 8'h35, 1, 0);
        addStep(stepIssue,  hitMapReqPkg::opReadRow, 8'h30, 1, 0);
        addStep(stepIssue,  hitMapReqPkg::opReadBit, 8'h34, 1, 0);     // neighbours stay 0
        addStep(stepIssue,  hitMapReqPkg::opReadBit, 8'h36, 1, 0);
        addStep(stepIssue,  hitMapReqPkg::opReadBit, 8'h45, 1, 0);
        addStep(stepIssue,  hitMapReqPkg::opSetHit,  8'h70, 6, 3);     // same row every cycle
        addStep(stepIssue,  hitMapReqPkg::opReadRow, 8'h70, 1, 0);     // needs forwarding
        addStep(stepDrain,  hitMapReqPkg::opSetHit,  8'h00, 1, 0);
        addStep(stepRandom, hitMapReqPkg::opSetHit,  8'h00, 48, 0);
        addStep(stepDrain,  hitMapReqPkg::opSetHit,  8'h00, 1, 0);
        addStep(stepReset,  hitMapReqPkg::opSetHit,  8'h00, 1, 0);     // second clear
        addStep(stepIssue,  hitMapReqPkg::opReadRow, 8'h00, 16, 16);
        addStep(stepIssue,  hitMapReqPkg::opReadBit, 8'h35, 1, 0);
        addStep(stepDrain,  hitMapReqPkg::opSetHit,  8'h00, 1, 0);
    endtask

    initial begin
        int total;
        reset    = 1'b1;
        reqValid = 1'b0;
        reqOp    = hitMapReqPkg::opSetHit;
        reqSsid  = '0;
        credits  = '0;
        issued   = 0;
        returned = 0;
        lfsr     = 32'hb154_7308;
        total    = 0;
        loadTable();
        foreach (steps[i]) total += steps[i].count;
        watchdogCycles = total * 8 + hitMapGeomPkg::NumRows + 50;
        foreach (steps[i]) runStep(steps[i]);
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // ends a hung run
    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
        $display("%0d checks, %0d errors", checkCount, errorCount);
        $display("test failed");
        $finish;
    end

endmodule

// File: verilog/hitMapTop.sv
`timescale 1ns/100ps

module hitMapTop (
    input  logic                clk,
    input  logic                reset,
    input  logic                reqValid,
    input  hitMapReqPkg::hitOpT reqOp,
    input  hitMapGeomPkg::ssidT reqSsid,
    output logic                respValid,
    output hitMapGeomPkg::ssidT respSsid,
    output logic                respBit,
    output hitMapGeomPkg::hitRowT respRow,
    output logic                creditReturn,
    output logic                busy
);

    hitMapGeomPkg::rowIndexT memRdRow;      // pipe read address
    hitMapGeomPkg::hitRowT   memRdData;
    logic                    pipeWrEn;      // write-back before the clearer mux
    hitMapGeomPkg::rowIndexT pipeWrRow;
    hitMapGeomPkg::hitRowT   pipeWrData;
    logic                    memWrEn;       // after the mux
    hitMapGeomPkg::rowIndexT memWrRow;
    hitMapGeomPkg::hitRowT   memWrData;

    hitUpdatePipe u_pipe (
        .clk          (clk),
        .reset        (reset),
        .reqValid     (reqValid),
        .reqOp        (reqOp),
        .reqSsid      (reqSsid),
        .rdRow        (memRdRow),
        .rdData       (memRdData),
        .wrEn         (pipeWrEn),
        .wrRow        (pipeWrRow),
        .wrData       (pipeWrData),
        .respValid    (respValid),
        .respSsid     (respSsid),
        .respBit      (respBit),
        .respRow      (respRow),
        .creditReturn (creditReturn)
    );

    hitMapClearer u_clearer (
        .clk        (clk),
        .reset      (reset),
        .pipeWrEn   (pipeWrEn),
        .pipeWrRow  (pipeWrRow),
        .pipeWrData (pipeWrData),
        .wrEn       (memWrEn),
        .wrRow      (memWrRow),
        .wrData     (memWrData),
        .busy       (busy)
    );

    hitRowMemory u_memory (
        .clk    (clk),
        .wrEn   (memWrEn),
        .wrRow  (memWrRow),
        .wrData (memWrData),
        .rdRow  (memRdRow),
        .rdData (memRdData)
    );

endmodule

// File: verilog/hitUpdatePipe.sv
`timescale 1ns/100ps

module hitUpdatePipe (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    reqValid,
    input  hitMapReqPkg::hitOpT     reqOp,
    input  hitMapGeomPkg::ssidT     reqSsid,
    output hitMapGeomPkg::rowIndexT rdRow,
    input  hitMapGeomPkg::hitRowT   rdData,
    output logic                    wrEn,
    output hitMapGeomPkg::rowIndexT wrRow,
    output hitMapGeomPkg::hitRowT   wrData,
    output logic                    respValid,
    output hitMapGeomPkg::ssidT     respSsid,
    output logic                    respBit,
    output hitMapGeomPkg::hitRowT   respRow,
    output logic                    creditReturn
);

    // request stages, index 0 is the cycle after acceptance
    logic [hitMapReqPkg::PipeDepth-1:0] stValid;
    hitMapReqPkg::hitOpT                stOp   [hitMapReqPkg::PipeDepth];
    hitMapGeomPkg::ssidT                stSsid [hitMapReqPkg::PipeDepth];

    // recent write-backs, index 0 is the one from the previous cycle
    logic [hitMapReqPkg::ReadLatency-1:0] fwdValid;
    hitMapGeomPkg::rowIndexT              fwdRow  [hitMapReqPkg::ReadLatency];
    hitMapGeomPkg::hitRowT                fwdData [hitMapReqPkg::ReadLatency];

    // last stage view
    logic                    lastValid;
    hitMapReqPkg::hitOpT     lastOp;
    hitMapGeomPkg::ssidT     lastSsid;
    hitMapGeomPkg::rowIndexT lastRow;
    hitMapGeomPkg::colIndexT lastCol;
    hitMapGeomPkg::hitRowT   curRow;    // freshest value of the row
    logic                    lastIsRead;

    // credits spent by the host and not yet returned
    hitMapReqPkg::creditCountT inFlight;

    always_ff @(posedge clk) begin
        if (reset) begin
            stValid <= '0;              // drop everything in flight
        end else begin
            stValid <= {stValid[hitMapReqPkg::PipeDepth-2:0], reqValid};
        end
    end

    always_ff @(posedge clk) begin
        stOp[0]   <= reqOp;
        stSsid[0] <= reqSsid;
        for (int i = 1; i < hitMapReqPkg::PipeDepth; i++) begin
            stOp[i]   <= stOp[i-1];
            stSsid[i] <= stSsid[i-1];
        end
    end

    // row read goes out from the first stage, data lands in the last one
    assign rdRow = stSsid[0][hitMapGeomPkg::ColBits +: hitMapGeomPkg::RowBits];

    assign lastValid  = stValid[hitMapReqPkg::PipeDepth-1];
    assign lastOp     = stOp[hitMapReqPkg::PipeDepth-1];
    assign lastSsid   = stSsid[hitMapReqPkg::PipeDepth-1];
    assign {lastRow, lastCol} = lastSsid;
    assign lastIsRead = (lastOp == hitMapReqPkg::opReadBit) ||
                        (lastOp == hitMapReqPkg::opReadRow);

    // memory misses writes made while this read was in flight
    always_comb begin
        curRow = rdData;
        for (int i = hitMapReqPkg::ReadLatency - 1; i >= 0; i--) begin
            if (fwdValid[i] && (fwdRow[i] == lastRow)) begin
                curRow = fwdData[i];    // newer write wins
            end
        end
    end

    // set hit write-back, read-modify-write in one cycle
    assign wrEn   = lastValid && (lastOp == hitMapReqPkg::opSetHit);
    assign wrRow  = lastRow;
    assign wrData = curRow | (hitMapGeomPkg::hitRowT'(1) << lastCol);

    always_ff @(posedge clk) begin
        if (reset) begin
            fwdValid <= '0;
        end else begin
            fwdValid <= {fwdValid[hitMapReqPkg::ReadLatency-2:0], wrEn};
        end
    end

    always_ff @(posedge clk) begin
        fwdRow[0]  <= wrRow;
        fwdData[0] <= wrData;
        for (int i = 1; i < hitMapReqPkg::ReadLatency; i++) begin
            fwdRow[i]  <= fwdRow[i-1];
            fwdData[i] <= fwdData[i-1];
        end
    end

    // retire, every request gives one credit back
    always_ff @(posedge clk) begin
        if (reset) begin
            respValid    <= 1'b0;
            creditReturn <= 1'b0;
        end else begin
            respValid    <= lastValid && lastIsRead;    // set hits stay silent
            creditReturn <= lastValid;
        end
    end

    always_ff @(posedge clk) begin
        respSsid <= lastSsid;
        respBit  <= curRow[lastCol];
        respRow  <= curRow;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inFlight <= '0;
        end else begin
            inFlight <= inFlight + hitMapReqPkg::creditCountT'(reqValid)
                                 - hitMapReqPkg::creditCountT'(creditReturn);
        end
    end

    // host must not issue beyond its credits
    creditBound: assert property (@(posedge clk) disable iff (reset)
        inFlight <= hitMapReqPkg::NumCredits)
        else $error("requests in flight exceed host credits");

    legalOp: assert property (@(posedge clk) disable iff (reset)
        reqValid |-> (reqOp inside {hitMapReqPkg::opSetHit, hitMapReqPkg::opReadBit,
                                    hitMapReqPkg::opReadRow}))
        else $error("request with unknown opcode");

endmodule

// File: verilog/hitMapClearer.sv
`timescale 1ns/100ps

module hitMapClearer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pipeWrEn,
    input  hitMapGeomPkg::rowIndexT pipeWrRow,
    input  hitMapGeomPkg::hitRowT   pipeWrData,
    output logic                    wrEn,
    output hitMapGeomPkg::rowIndexT wrRow,
    output hitMapGeomPkg::hitRowT   wrData,
    output logic                    busy
);

    typedef enum logic {
        clearIdle,  // pipe owns the write port
        clearSweep  // zeroing rows, one per cycle
    } clearStateT;

    clearStateT              state;
    hitMapGeomPkg::rowIndexT clearRow;  // row being zeroed this cycle
    logic                    sweeping;

    assign sweeping = (state == clearSweep);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= clearSweep;     // sweep restarts on every reset
            clearRow <= '0;
        end else begin
            case (state)
                clearSweep: begin
                    clearRow <= clearRow + 1'b1;
                    if (clearRow == hitMapGeomPkg::rowIndexT'(hitMapGeomPkg::NumRows - 1)) begin
                        state <= clearIdle; // last row goes out this cycle
                    end
                end
                default: begin
                    state <= clearIdle;
                end
            endcase
        end
    end

    // write port mux, sweep has priority
    always_comb begin
        if (sweeping) begin
            wrEn   = 1'b1;
            wrRow  = clearRow;
            wrData = '0;                // empty row
        end else begin
            wrEn   = pipeWrEn;          // pass the pipe's write-back through
            wrRow  = pipeWrRow;
            wrData = pipeWrData;
        end
    end

    assign busy = sweeping;             // high for NumRows cycles after reset falls

    // host holds requests while busy, so the pipe has nothing to write back
    noPipeWriteInSweep: assert property (@(posedge clk) disable iff (reset)
        sweeping |-> !pipeWrEn)
        else $error("pipe write-back collided with the clear sweep");

endmodule

// File: verilog/hitRowMemory.sv
`timescale 1ns/100ps

module hitRowMemory (
    input  logic                    clk,
    input  logic                    wrEn,
    input  hitMapGeomPkg::rowIndexT wrRow,
    input  hitMapGeomPkg::hitRowT   wrData,
    input  hitMapGeomPkg::rowIndexT rdRow,
    output hitMapGeomPkg::hitRowT   rdData
);

    // block ram model, one write port and one read port
    hitMapGeomPkg::hitRowT rowStore [hitMapGeomPkg::NumRows];

    // registered read path, stage 0 is the array output register
    hitMapGeomPkg::hitRowT rdPipe [hitMapReqPkg::ReadLatency];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            rowStore[wrRow] <= wrData;  // commits at the edge ending the write cycle
        end
    end

    always_ff @(posedge clk) begin
        rdPipe[0] <= rowStore[rdRow];   // old data on a same-cycle write
        for (int i = 1; i < hitMapReqPkg::ReadLatency; i++) begin
            rdPipe[i] <= rdPipe[i-1];   // output register stages
        end
    end

    // data for an address of cycle c shows up in cycle c + ReadLatency
    assign rdData = rdPipe[hitMapReqPkg::ReadLatency-1];

endmodule

// File: verilog/hitMapReqPkg.sv
package hitMapReqPkg;

    // host request codes
    typedef enum logic [1:0] {
        opSetHit  = 2'd0,   // OR one bit into its row
        opReadBit = 2'd1,   // return the stored bit of one ssid
        opReadRow = 2'd2    // return a whole row
    } hitOpT;

    localparam int ReadLatency = 2;                 // memory read cycles
    localparam int PipeDepth   = ReadLatency + 1;   // stages a request occupies

    // host owns this many credits after reset
    localparam int NumCredits = 4;

    // wide enough to hold NumCredits itself
    typedef logic [$clog2(NumCredits+1)-1:0] creditCountT;

endpackage

// File: verilog/hitMapGeomPkg.sv
package hitMapGeomPkg;

    // the map is a grid of rows, each row a word of column bits
    localparam int NumRows = 16;                // rows in the map
    localparam int NumCols = 16;                // hit bits per row
    localparam int RowBits = $clog2(NumRows);   // row address width
    localparam int ColBits = $clog2(NumCols);   // column index width

    // row address into the memory
    typedef logic [RowBits-1:0] rowIndexT;

    // bit position inside one row
    typedef logic [ColBits-1:0] colIndexT;

    // superstrip id, row in the upper bits and column in the lower bits
    typedef logic [RowBits+ColBits-1:0] ssidT;

    // one full row of hit bits
    typedef logic [NumCols-1:0] hitRowT;

endpackage
